// File: flist.f
+incdir+rtl
rtl/comms_pkg.sv
rtl/bram_if.sv
rtl/uart_frame_rx.sv
rtl/uart_frame_tx.sv
rtl/block_ram.sv
rtl/comms.sv
rtl/accel_link_top.sv
tb/accel_link_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f flist.f --top-module accel_link_tb
	out=$$(./obj_dir/Vaccel_link_tb); echo "$$out"; echo "$$out" | grep -q "Test passed"

clean:
	rm -rf obj_dir

// File: tb/accel_link_tb.sv
`include "comms_cfg.svh"

module accel_link_tb import comms_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int RATIO = `COMMS_CLK_BAUD_RATIO;
  localparam int FRAME_CYCLES = 10 * RATIO;
  localparam int START_TIMEOUT = 20 * FRAME_CYCLES; // Covers the header plus fetch latency
  localparam int IDLE_TIMEOUT = 200 * FRAME_CYCLES;

  typedef struct {
    string name;
    logic read;
    target_t target;
    int block;
  } cmd_t;

  logic clk_in;
  logic rst_in;
  logic rx;
  logic tx;
  logic busy;
  inf_word_t inf_result;

  logic [16:0] lfsr_state;
  cmd_t cmds [$];
  data_word_t data_model [`COMMS_DATA_DEPTH];
  weight_word_t weight_model [`COMMS_WEIGHT_DEPTH];
  op_word_t op_model [`COMMS_OP_DEPTH];
  inf_word_t inf_value;
  logic [7:0] rx_bytes [$];

  accel_link_top i_accel_link_top (
    .clk_in(clk_in),
    .rst_in(rst_in),
    .rx(rx),
    .tx(tx),
    .busy(busy),
    .inf_result(inf_result)
  );

  always #50 clk_in = ~clk_in;

  // x^17 + x^14 + 1
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[16] ^ lfsr_state[13];
    lfsr_state = {lfsr_state[15:0], fb};
    return fb;
  endfunction

  function automatic logic [127:0] rand_bits(input int nbits);
    logic [127:0] v;
    v = '0;
    for (int i = 0; i < nbits; i++) begin
      v[i] = lfsr_bit();
    end
    return v;
  endfunction

  function automatic int piece_count(input target_t t);
    int n;
    case (t)
      TARGET_DATA: n = `COMMS_DATA_PIECES;
      TARGET_WEIGHT: n = `COMMS_WEIGHT_PIECES;
      TARGET_OP: n = `COMMS_OP_PIECES;
      default: n = 1; // Inference register is one wide piece
    endcase
    return n;
  endfunction

  function automatic int piece_bytes(input target_t t);
    int n;
    case (t)
      TARGET_DATA: n = `COMMS_DATA_WIDTH / 8;
      TARGET_WEIGHT: n = `COMMS_WEIGHT_WIDTH / 8;
      TARGET_OP: n = `COMMS_OP_WIDTH / 8;
      default: n = `COMMS_INF_WIDTH / 8;
    endcase
    return n;
  endfunction

  // Type byte low, block number above
  function automatic header_t make_header(input logic read, input target_t t, input int block);
    header_t h;
    h = '0;
    h[1:0] = t;
    h[2] = read;
    h[$bits(header_t)-1:8] = block[15:0];
    return h;
  endfunction

  function automatic cmd_t make_cmd(input string name, input logic read, input target_t t,
                                    input int block);
    cmd_t c;
    c.name = name;
    c.read = read;
    c.target = t;
    c.block = block;
    return c;
  endfunction

  task automatic stop_run();
    $display("Test failed");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic check_data(input string name, input data_word_t exp, input data_word_t act);
    if (act !== exp) begin
      $display("Mismatch %s: expected %h, actual %h", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_weight(input string name, input weight_word_t exp,
                              input weight_word_t act);
    if (act !== exp) begin
      $display("Mismatch %s: expected %h, actual %h", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_op(input string name, input op_word_t exp, input op_word_t act);
    if (act !== exp) begin
      $display("Mismatch %s: expected %h, actual %h", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_inf(input string name, input inf_word_t exp, input inf_word_t act);
    if (act !== exp) begin
      $display("Mismatch %s: expected %h, actual %h", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_busy(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Mismatch %s busy: expected %b, actual %b", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_line(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Mismatch %s tx line: expected %b, actual %b", name, exp, act);
      stop_run();
    end
  endtask

  // Start bit, 8 data bits LSB first, stop bit
  task automatic send_byte(input logic [7:0] b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    @(posedge clk_in);
    for (int i = 0; i < 10; i++) begin
      rx <= frame[i];
      repeat (RATIO) @(posedge clk_in);
    end
  endtask

  task automatic send_bytes(input logic [127:0] w, input int nbytes);
    for (int i = 0; i < nbytes; i++) begin
      send_byte(w[i*8 +: 8]);
    end
  endtask

  task automatic receive_byte(input string name, output logic [7:0] b);
    int waited;
    waited = 0;
    b = '0;
    @(negedge clk_in);
    while (tx !== 1'b0) begin
      if (waited == START_TIMEOUT) begin
        $display("No start bit came from the DUT during %s", name);
        stop_run();
      end
      waited++;
      @(negedge clk_in);
    end
    repeat (RATIO / 2) @(negedge clk_in); // Middle of start bit
    check_line(name, 1'b0, tx);
    for (int i = 0; i < 8; i++) begin
      repeat (RATIO) @(negedge clk_in);
      b[i] = tx;
    end
    repeat (RATIO) @(negedge clk_in);
    check_line(name, 1'b1, tx); // Stop bit
  endtask

  task automatic wait_not_busy(input string name);
    int waited;
    waited = 0;
    @(negedge clk_in);
    while (busy !== 1'b0) begin
      if (waited == IDLE_TIMEOUT) begin
        $display("The DUT stayed busy after %s", name);
        stop_run();
      end
      waited++;
      @(negedge clk_in);
    end
  endtask

  task automatic run_write(input cmd_t c);
    int n;
    int base;
    logic [127:0] w;
    n = piece_count(c.target);
    base = c.block * n;
    send_bytes(128'(make_header(1'b0, c.target, c.block)), `COMMS_HEADER_FRAMES);
    @(negedge clk_in);
    check_busy(c.name, 1'b1, busy);
    for (int p = 0; p < n; p++) begin
      w = rand_bits(piece_bytes(c.target) * 8);
      case (c.target)
        TARGET_DATA: data_model[data_addr_t'(base + p)] = data_word_t'(w);
        TARGET_WEIGHT: weight_model[weight_addr_t'(base + p)] = weight_word_t'(w);
        default: op_model[op_addr_t'(base + p)] = op_word_t'(w);
      endcase
      send_bytes(w, piece_bytes(c.target));
    end
    wait_not_busy(c.name);
  endtask

  task automatic run_read(input cmd_t c);
    int n;
    int nb;
    int base;
    logic [127:0] got;
    logic [7:0] b;
    n = piece_count(c.target);
    nb = piece_bytes(c.target);
    base = c.block * n;
    rx_bytes.delete();
    // Reply may start before the header stop bit ends
    fork
      begin
        send_bytes(128'(make_header(1'b1, c.target, c.block)), `COMMS_HEADER_FRAMES);
        @(negedge clk_in);
        check_busy(c.name, 1'b1, busy);
      end
      begin
        for (int i = 0; i < n * nb; i++) begin
          receive_byte(c.name, b);
          rx_bytes.push_back(b);
        end
      end
    join
    check_busy(c.name, 1'b1, busy); // Last stop bit still on the line
    for (int p = 0; p < n; p++) begin
      got = '0;
      for (int k = 0; k < nb; k++) begin
        got[k*8 +: 8] = rx_bytes[p*nb + k];
      end
      case (c.target)
        TARGET_DATA:
          check_data(c.name, data_model[data_addr_t'(base + p)], data_word_t'(got));
        TARGET_WEIGHT:
          check_weight(c.name, weight_model[weight_addr_t'(base + p)], weight_word_t'(got));
        TARGET_OP:
          check_op(c.name, op_model[op_addr_t'(base + p)], op_word_t'(got));
        default: check_inf(c.name, inf_value, inf_word_t'(got));
      endcase
    end
    wait_not_busy(c.name);
  endtask

  initial begin
    clk_in = 1'b0;
    rst_in <= 1'b1;
    rx <= 1'b1;
    inf_result <= '0;
    lfsr_state = 17'd97427;
    cmds.push_back(make_cmd("data_wr_b3", 1'b0, TARGET_DATA, 3));
    cmds.push_back(make_cmd("data_rd_b3", 1'b1, TARGET_DATA, 3));
    cmds.push_back(make_cmd("weight_wr_b0", 1'b0, TARGET_WEIGHT, 0));
    cmds.push_back(make_cmd("weight_wr_b1", 1'b0, TARGET_WEIGHT, 1));
    cmds.push_back(make_cmd("weight_rd_b0", 1'b1, TARGET_WEIGHT, 0));
    cmds.push_back(make_cmd("weight_rd_b1", 1'b1, TARGET_WEIGHT, 1));
    cmds.push_back(make_cmd("data_rd_b3_again", 1'b1, TARGET_DATA, 3));
    cmds.push_back(make_cmd("op_wr_b5", 1'b0, TARGET_OP, 5));
    cmds.push_back(make_cmd("op_wr_b12", 1'b0, TARGET_OP, 12));
    cmds.push_back(make_cmd("op_wr_b63", 1'b0, TARGET_OP, 63));
    cmds.push_back(make_cmd("op_rd_b12", 1'b1, TARGET_OP, 12));
    cmds.push_back(make_cmd("op_rd_b5", 1'b1, TARGET_OP, 5));
    cmds.push_back(make_cmd("op_rd_b63", 1'b1, TARGET_OP, 63));
    cmds.push_back(make_cmd("inf_rd", 1'b1, TARGET_INF, 0));

    repeat (8) @(posedge clk_in);
    rst_in <= 1'b0;
    inf_value = inf_word_t'(rand_bits(`COMMS_INF_WIDTH));
    inf_result <= inf_value;

    // Quiet link after reset
    for (int i = 0; i < 3 * FRAME_CYCLES; i++) begin
      @(negedge clk_in);
      check_busy("reset_idle", 1'b0, busy);
      check_line("reset_idle", 1'b1, tx);
    end

    foreach (cmds[i]) begin
      if (cmds[i].read) begin
        run_read(cmds[i]);
      end else begin
        run_write(cmds[i]);
      end
    end

    $display("Test passed");
    $finish;
  end

endmodule

// File: rtl/accel_link_top.sv
`include "comms_cfg.svh"

module accel_link_top import comms_pkg::*; (
  input  logic      clk_in,
  input  logic      rst_in,
  input  logic      rx,
  output logic      tx,
  output logic      busy,
  input  inf_word_t inf_result
);

  bram_if #(
    .ADDR_W($bits(data_addr_t)),
    .DATA_W($bits(data_word_t))
  ) data_bus ();

  bram_if #(
    .ADDR_W($bits(weight_addr_t)),
    .DATA_W($bits(weight_word_t))
  ) weight_bus ();

  bram_if #(
    .ADDR_W($bits(op_addr_t)),
    .DATA_W($bits(op_word_t))
  ) op_bus ();

  comms i_comms (
    .clk_in(clk_in),
    .rst_in(rst_in),
    .rx(rx),
    .tx(tx),
    .busy(busy),
    .inf_result(inf_result), // Stands in for the inference engine
    .data_mem(data_bus.ctrl),
    .weight_mem(weight_bus.ctrl),
    .op_mem(op_bus.ctrl)
  );

  block_ram #(
    .DEPTH(`COMMS_DATA_DEPTH),
    .WIDTH(`COMMS_DATA_WIDTH)
  ) i_data_ram (
    .clk_in(clk_in),
    .mem(data_bus.mem)
  );

  block_ram #(
    .DEPTH(`COMMS_WEIGHT_DEPTH),
    .WIDTH(`COMMS_WEIGHT_WIDTH)
  ) i_weight_ram (
    .clk_in(clk_in),
    .mem(weight_bus.mem)
  );

  block_ram #(
    .DEPTH(`COMMS_OP_DEPTH),
    .WIDTH(`COMMS_OP_WIDTH)
  ) i_op_ram (
    .clk_in(clk_in),
    .mem(op_bus.mem)
  );

endmodule

// File: rtl/comms.sv
`include "comms_cfg.svh"

module comms import comms_pkg::*; (
  input  logic      clk_in,
  input  logic      rst_in,
  input  logic      rx,
  output logic      tx,
  output logic      busy,
  input  inf_word_t inf_result,
  bram_if.ctrl      data_mem,
  bram_if.ctrl      weight_mem,
  bram_if.ctrl      op_mem
);

  localparam int FB = `COMMS_FRAME_BITS;
  localparam int INF_PIECES = 1;
  localparam int MAX_PIECES = (`COMMS_DATA_PIECES > `COMMS_WEIGHT_PIECES) ?
                              `COMMS_DATA_PIECES : `COMMS_WEIGHT_PIECES; // Op is 1
  localparam int CNT_W = $clog2(MAX_PIECES + 1);

  link_state_t state;
  target_t target;
  header_t header_word;
  logic header_valid;
  logic [$bits(header_t)-FB-1:0] block_num;
  logic [CNT_W-1:0] piece_cnt;
  logic [CNT_W-1:0] piece_total;

  data_addr_t data_addr;
  weight_addr_t weight_addr;
  op_addr_t op_addr;
  data_word_t data_piece;
  weight_word_t weight_piece;
  op_word_t op_piece;
  logic data_valid, weight_valid, op_valid;
  logic piece_valid;

  logic tx_data, tx_weight, tx_op, tx_inf;
  logic busy_data, busy_weight, busy_op, busy_inf;
  logic tx_busy_sel;
  logic fetch_now;
  logic send_now;

  assign block_num = header_word[$bits(header_t)-1:FB];
  assign busy = (state != LINK_IDLE) && (state != LINK_DONE);
  assign tx = tx_data & tx_weight & tx_op & tx_inf;

  uart_frame_rx #(.FRAMES(`COMMS_HEADER_FRAMES)) i_rx_header (
    .clk_in(clk_in), .rst_in(rst_in), .enable(state == LINK_IDLE), .rx(rx),
    .data(header_word), .valid(header_valid)
  );

  uart_frame_rx #(.FRAMES(`COMMS_DATA_WIDTH / FB)) i_rx_data (
    .clk_in(clk_in), .rst_in(rst_in),
    .enable(state == LINK_RECEIVE && target == TARGET_DATA), .rx(rx),
    .data(data_piece), .valid(data_valid)
  );

  uart_frame_rx #(.FRAMES(`COMMS_WEIGHT_WIDTH / FB)) i_rx_weight (
    .clk_in(clk_in), .rst_in(rst_in),
    .enable(state == LINK_RECEIVE && target == TARGET_WEIGHT), .rx(rx),
    .data(weight_piece), .valid(weight_valid)
  );

  uart_frame_rx #(.FRAMES(`COMMS_OP_WIDTH / FB)) i_rx_op (
    .clk_in(clk_in), .rst_in(rst_in),
    .enable(state == LINK_RECEIVE && target == TARGET_OP), .rx(rx),
    .data(op_piece), .valid(op_valid)
  );

  uart_frame_tx #(.FRAMES(`COMMS_DATA_WIDTH / FB)) i_tx_data (
    .clk_in(clk_in), .rst_in(rst_in), .start(send_now && target == TARGET_DATA),
    .data(data_mem.rdata), .tx(tx_data), .busy(busy_data)
  );

  uart_frame_tx #(.FRAMES(`COMMS_WEIGHT_WIDTH / FB)) i_tx_weight (
    .clk_in(clk_in), .rst_in(rst_in), .start(send_now && target == TARGET_WEIGHT),
    .data(weight_mem.rdata), .tx(tx_weight), .busy(busy_weight)
  );

  uart_frame_tx #(.FRAMES(`COMMS_OP_WIDTH / FB)) i_tx_op (
    .clk_in(clk_in), .rst_in(rst_in), .start(send_now && target == TARGET_OP),
    .data(op_mem.rdata), .tx(tx_op), .busy(busy_op)
  );

  uart_frame_tx #(.FRAMES(`COMMS_INF_WIDTH / FB)) i_tx_inf (
    .clk_in(clk_in), .rst_in(rst_in), .start(send_now && target == TARGET_INF),
    .data(inf_result), .tx(tx_inf), .busy(busy_inf)
  );

  // Per-target selection
  always_comb begin
    case (target)
      TARGET_DATA: begin
        piece_valid = data_valid;
        tx_busy_sel = busy_data;
        piece_total = CNT_W'(`COMMS_DATA_PIECES);
      end
      TARGET_WEIGHT: begin
        piece_valid = weight_valid;
        tx_busy_sel = busy_weight;
        piece_total = CNT_W'(`COMMS_WEIGHT_PIECES);
      end
      TARGET_OP: begin
        piece_valid = op_valid;
        tx_busy_sel = busy_op;
        piece_total = CNT_W'(`COMMS_OP_PIECES);
      end
      default: begin
        piece_valid = 1'b0;
        tx_busy_sel = busy_inf;
        piece_total = CNT_W'(INF_PIECES);
      end
    endcase
  end

  assign fetch_now = (state == LINK_FETCH) && !tx_busy_sel && (piece_cnt != piece_total);
  assign send_now = (state == LINK_SEND);

  assign data_mem.addr = data_addr;
  assign data_mem.wdata = data_piece;
  assign data_mem.we = (state == LINK_WRITE) && (target == TARGET_DATA);
  assign data_mem.re = fetch_now && (target == TARGET_DATA);

  assign weight_mem.addr = weight_addr;
  assign weight_mem.wdata = weight_piece;
  assign weight_mem.we = (state == LINK_WRITE) && (target == TARGET_WEIGHT);
  assign weight_mem.re = fetch_now && (target == TARGET_WEIGHT);

  assign op_mem.addr = op_addr;
  assign op_mem.wdata = op_piece;
  assign op_mem.we = (state == LINK_WRITE) && (target == TARGET_OP);
  assign op_mem.re = fetch_now && (target == TARGET_OP);

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state <= LINK_IDLE;
      piece_cnt <= '0;
    end else begin
      case (state)
        LINK_IDLE: begin
          if (header_valid) begin
            piece_cnt <= '0;
            if (header_word[2]) begin
              state <= LINK_FETCH;
            end else if (header_word[1:0] == TARGET_INF) begin
              state <= LINK_DONE; // Nothing to write
            end else begin
              state <= LINK_RECEIVE;
            end
          end
        end
        LINK_RECEIVE: if (piece_valid) state <= LINK_WRITE;
        LINK_WRITE: begin
          piece_cnt <= piece_cnt + 1'b1;
          if (piece_cnt == piece_total - 1'b1) begin
            state <= LINK_DONE;
          end else begin
            state <= LINK_RECEIVE;
          end
        end
        LINK_FETCH: begin
          // Last piece out and its line idle again
          if (!tx_busy_sel) begin
            state <= (piece_cnt == piece_total) ? LINK_DONE : LINK_SEND;
          end
        end
        LINK_SEND: begin
          piece_cnt <= piece_cnt + 1'b1;
          state <= LINK_FETCH;
        end
        default: state <= LINK_IDLE;
      endcase
    end
  end

  // Block start address, then one step per piece moved
  always_ff @(posedge clk_in) begin
    if (state == LINK_IDLE && header_valid) begin
      target <= header_word[1:0];
      data_addr <= data_addr_t'(block_num * `COMMS_DATA_PIECES);
      weight_addr <= weight_addr_t'(block_num * `COMMS_WEIGHT_PIECES);
      op_addr <= op_addr_t'(block_num * `COMMS_OP_PIECES);
    end else if (state == LINK_WRITE || state == LINK_SEND) begin
      case (target)
        TARGET_DATA: data_addr <= data_addr + 1'b1;
        TARGET_WEIGHT: weight_addr <= weight_addr + 1'b1;
        TARGET_OP: op_addr <= op_addr + 1'b1;
        default: ;
      endcase
    end
  end

  // A header outside idle would be lost
  a_header_idle: assert property (@(posedge clk_in) disable iff (rst_in)
    header_valid |-> (state == LINK_IDLE));

  // Every payload piece lands while the FSM waits for it
  a_piece_receive: assert property (@(posedge clk_in) disable iff (rst_in)
    piece_valid |-> (state == LINK_RECEIVE));

endmodule

// File: rtl/block_ram.sv
module block_ram #(
  parameter int DEPTH = 256,
  parameter int WIDTH = 64
) (
  input logic  clk_in,
  bram_if.mem  mem
);

  logic [WIDTH-1:0] ram [DEPTH];

  always_ff @(posedge clk_in) begin
    if (mem.we) begin
      ram[mem.addr] <= mem.wdata;
    end
  end

  // Registered read port
  always_ff @(posedge clk_in) begin
    if (mem.re) begin
      mem.rdata <= ram[mem.addr];
    end
  end

  a_no_read_write: assert property (@(posedge clk_in)
    !(mem.we && mem.re));

endmodule

// File: rtl/uart_frame_tx.sv
`include "comms_cfg.svh"

module uart_frame_tx import comms_pkg::*; #(
  parameter int FRAMES = 1
) (
  input  logic                                clk_in,
  input  logic                                rst_in,
  input  logic                                start,
  input  logic [FRAMES*`COMMS_FRAME_BITS-1:0] data,
  output logic                                tx,
  output logic                                busy
);

  localparam int FB = `COMMS_FRAME_BITS;
  localparam int W = FRAMES * FB;
  localparam int RATIO = `COMMS_CLK_BAUD_RATIO;
  localparam int BAUD_W = $clog2(RATIO);
  localparam int BIT_W = $clog2(FB);
  localparam int FRAME_W = $clog2(FRAMES + 1);

  tx_state_t state;
  logic [BAUD_W-1:0] baud_cnt;
  logic [BIT_W-1:0] bit_cnt;
  logic [FRAME_W-1:0] frame_cnt;
  logic [W-1:0] word_sr;
  logic baud_done;

  assign baud_done = (baud_cnt == '0);
  assign busy = (state != TX_IDLE);

  always_comb begin
    case (state)
      TX_START: tx = 1'b0;
      TX_BITS: tx = word_sr[0];
      default: tx = 1'b1; // Idle and stop are high
    endcase
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state <= TX_IDLE;
      baud_cnt <= '0;
      bit_cnt <= '0;
      frame_cnt <= '0;
    end else begin
      if (state == TX_IDLE || baud_done) begin
        baud_cnt <= BAUD_W'(RATIO - 1);
      end else begin
        baud_cnt <= baud_cnt - 1'b1;
      end
      case (state)
        TX_IDLE: begin
          if (start) begin
            state <= TX_START;
            frame_cnt <= '0;
          end
        end
        TX_START: begin
          if (baud_done) begin
            state <= TX_BITS;
            bit_cnt <= '0;
          end
        end
        TX_BITS: begin
          if (baud_done) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == BIT_W'(FB - 1)) state <= TX_STOP;
          end
        end
        default: begin
          if (baud_done) begin
            if (frame_cnt == FRAME_W'(FRAMES - 1)) begin
              state <= TX_IDLE;
            end else begin
              frame_cnt <= frame_cnt + 1'b1;
              state <= TX_START;
            end
          end
        end
      endcase
    end
  end

  // One shift per data bit walks through the bytes low first
  always_ff @(posedge clk_in) begin
    if (state == TX_IDLE && start) begin
      word_sr <= data;
    end else if (state == TX_BITS && baud_done) begin
      word_sr <= word_sr >> 1;
    end
  end

  // A start while sending would be dropped
  a_start_idle: assert property (@(posedge clk_in) disable iff (rst_in)
    start |-> !busy);

endmodule

// File: rtl/uart_frame_rx.sv
`include "comms_cfg.svh"

module uart_frame_rx #(
  parameter int FRAMES = 1
) (
  input  logic                                clk_in,
  input  logic                                rst_in,
  input  logic                                enable,
  input  logic                                rx,
  output logic [FRAMES*`COMMS_FRAME_BITS-1:0] data,
  output logic                                valid
);

  localparam int FB = `COMMS_FRAME_BITS;
  localparam int W = FRAMES * FB;
  localparam int RATIO = `COMMS_CLK_BAUD_RATIO;
  localparam int BAUD_W = $clog2(RATIO);
  localparam int BIT_W = $clog2(FB + 2);
  localparam int FRAME_W = $clog2(FRAMES + 1);

  logic rx_meta;
  logic rx_sync;
  logic active;
  logic [BAUD_W-1:0] baud_cnt;
  logic [BIT_W-1:0] bit_idx; // 0 start, 1..FB data, FB+1 stop
  logic [FRAME_W-1:0] frame_cnt;
  logic [FB-1:0] byte_sr;
  logic [W+FB-1:0] merged;
  logic tick;
  logic stop_bit;

  assign tick = active && (baud_cnt == '0);
  assign stop_bit = (bit_idx == BIT_W'(FB + 1));
  assign merged = {byte_sr, data};

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      active <= 1'b0;
      baud_cnt <= '0;
      bit_idx <= '0;
      frame_cnt <= '0;
      valid <= 1'b0;
    end else begin
      valid <= 1'b0;
      if (!active) begin
        // Keep listening between frames of one word
        if (!rx_sync && (enable || frame_cnt != '0)) begin
          active <= 1'b1;
          baud_cnt <= BAUD_W'(RATIO / 2 - 1); // First tick lands mid start bit
          bit_idx <= '0;
        end
      end else if (baud_cnt != '0) begin
        baud_cnt <= baud_cnt - 1'b1;
      end else begin
        baud_cnt <= BAUD_W'(RATIO - 1);
        bit_idx <= bit_idx + 1'b1;
        if (bit_idx == '0) begin
          if (rx_sync) begin
            active <= 1'b0; // Glitch, not a start bit
          end
        end else if (stop_bit) begin
          active <= 1'b0;
          if (frame_cnt == FRAME_W'(FRAMES - 1)) begin
            frame_cnt <= '0;
            valid <= 1'b1;
          end else begin
            frame_cnt <= frame_cnt + 1'b1;
          end
        end
      end
    end
  end

  // Bits enter at the top, so the first byte ends up lowest
  always_ff @(posedge clk_in) begin
    if (tick) begin
      if (bit_idx != '0 && !stop_bit) begin
        byte_sr <= {rx_sync, byte_sr[FB-1:1]};
      end
      if (stop_bit) begin
        data <= merged[W+FB-1:FB];
      end
    end
  end

  a_valid_single: assert property (@(posedge clk_in) disable iff (rst_in)
    valid |=> !valid);

endmodule

// File: rtl/bram_if.sv
interface bram_if #(
  parameter int ADDR_W = 8,
  parameter int DATA_W = 64
) ();

  logic [ADDR_W-1:0] addr;
  logic [DATA_W-1:0] wdata;
  logic we;
  logic re;
  logic [DATA_W-1:0] rdata; // Valid the cycle after re

  modport ctrl (
    output addr,
    output wdata,
    output we,
    output re,
    input rdata
  );

  modport mem (
    input addr,
    input wdata,
    input we,
    input re,
    output rdata
  );

endinterface

// File: rtl/comms_pkg.sv
`include "comms_cfg.svh"

package comms_pkg;

  typedef logic [`COMMS_DATA_WIDTH-1:0] data_word_t;
  typedef logic [`COMMS_WEIGHT_WIDTH-1:0] weight_word_t;
  typedef logic [`COMMS_OP_WIDTH-1:0] op_word_t;
  typedef logic [`COMMS_INF_WIDTH-1:0] inf_word_t;

  typedef logic [$clog2(`COMMS_DATA_DEPTH)-1:0] data_addr_t;
  typedef logic [$clog2(`COMMS_WEIGHT_DEPTH)-1:0] weight_addr_t;
  typedef logic [$clog2(`COMMS_OP_DEPTH)-1:0] op_addr_t;

  // Type byte in [7:0], block number above it
  typedef logic [`COMMS_HEADER_FRAMES*`COMMS_FRAME_BITS-1:0] header_t;

  typedef logic [1:0] target_t;
  localparam target_t TARGET_DATA = 2'd0;
  localparam target_t TARGET_WEIGHT = 2'd1;
  localparam target_t TARGET_OP = 2'd2;
  localparam target_t TARGET_INF = 2'd3; // Read only

  typedef enum logic [2:0] {
    LINK_IDLE, LINK_RECEIVE, LINK_WRITE, LINK_FETCH, LINK_SEND, LINK_DONE
  } link_state_t;

  typedef enum logic [1:0] {
    TX_IDLE, TX_START, TX_BITS, TX_STOP
  } tx_state_t;

endpackage

// File: rtl/comms_cfg.svh
`ifndef COMMS_CFG_SVH
`define COMMS_CFG_SVH

// UART link
`define COMMS_CLK_BAUD_RATIO 8 // Clock cycles per bit, small for simulation
`define COMMS_FRAME_BITS 8
`define COMMS_HEADER_FRAMES 3

// Data memory
`define COMMS_DATA_WIDTH 64
`define COMMS_DATA_DEPTH 256
`define COMMS_DATA_PIECES 4

// Weight memory
`define COMMS_WEIGHT_WIDTH 64
`define COMMS_WEIGHT_DEPTH 512
`define COMMS_WEIGHT_PIECES 4

// Op memory
`define COMMS_OP_WIDTH 8
`define COMMS_OP_DEPTH 64
`define COMMS_OP_PIECES 1

// Half of one data block
`define COMMS_INF_WIDTH (`COMMS_DATA_WIDTH * `COMMS_DATA_PIECES / 2)

`endif
